// File: source/tl_pkg.sv
package tl_pkg;

  // Field widths of the host and device links
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned MaskWidth   = DataWidth / 8;
  localparam int unsigned SourceWidth = 4;
  localparam int unsigned SinkWidth   = 2;
  localparam int unsigned SizeWidth   = 3;

  // Largest message is 2**MaxSize bytes
  localparam int unsigned MaxSize      = 4;
  localparam int unsigned BeatBytesLog = 2;

  // Wide enough to hold the beat count of the largest message
  localparam int unsigned BeatCountWidth = MaxSize - BeatBytesLog + 1;

  typedef enum logic [2:0] {
    PutFullData  = 3'd0,
    Get          = 3'd4,
    AcquireBlock = 3'd6
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1,
    Grant         = 3'd4,
    GrantData     = 3'd5
  } tl_d_op_e;

  // Beats in a D message
  // Only the data-carrying opcodes span more than one beat
  function automatic logic [BeatCountWidth-1:0] tl_beats(input tl_d_op_e opcode,
                                                        input logic [SizeWidth-1:0] size);
    logic [SizeWidth-1:0]      eff_size;
    logic [BeatCountWidth-1:0] beats;
    eff_size = (size > SizeWidth'(MaxSize)) ? SizeWidth'(MaxSize) : size;
    beats    = BeatCountWidth'(1);
    if ((opcode inside {AccessAckData, GrantData}) && (eff_size > SizeWidth'(BeatBytesLog))) begin
      beats = BeatCountWidth'(1) << (eff_size - SizeWidth'(BeatBytesLog));
    end
    return beats;
  endfunction

endpackage

// File: source/socket_cfg_pkg.sv
package socket_cfg_pkg;
  import tl_pkg::*;

  // Device links behind the socket
  localparam int unsigned NumLinks  = 3;
  localparam int unsigned LinkWidth = 2;

  // Address routing table, highest index listed first
  // Overlapping ranges resolve to the entry with the larger index
  // An address outside every range goes to link 0
  localparam int unsigned NumAddressRange = 3;

  localparam logic [NumAddressRange-1:0][AddrWidth-1:0] AddressBase = {
    32'h2800_0000,
    32'h2000_0000,
    32'h1000_0000
  };
  localparam logic [NumAddressRange-1:0][AddrWidth-1:0] AddressMask = {
    32'h00FF_FFFF,
    32'h0FFF_FFFF,
    32'h0FFF_FFFF
  };
  localparam logic [NumAddressRange-1:0][LinkWidth-1:0] AddressLink = {
    2'd1,
    2'd2,
    2'd1
  };

  // Sink routing table for the E channel, highest index listed first
  localparam int unsigned NumSinkRange = 3;

  localparam logic [NumSinkRange-1:0][SinkWidth-1:0] SinkBase = {2'd0, 2'd2, 2'd1};
  localparam logic [NumSinkRange-1:0][SinkWidth-1:0] SinkMask = {2'd0, 2'd0, 2'd0};
  localparam logic [NumSinkRange-1:0][LinkWidth-1:0] SinkLink = {2'd0, 2'd2, 2'd1};

endpackage

// File: source/tl_route_decoder.sv
`timescale 1ns/10ps

module tl_route_decoder import tl_pkg::*; import socket_cfg_pkg::*; (
  input  logic [AddrWidth-1:0] a_address_i,
  input  logic [SinkWidth-1:0] e_sink_i,
  output logic [LinkWidth-1:0] a_link_o,
  output logic [LinkWidth-1:0] e_link_o
);

  // Address lookup
  // Later entries overwrite earlier ones, so the highest matching index wins
  always_comb begin
    a_link_o = '0;
    for (int i = 0; i < NumAddressRange; i++) begin
      if ((a_address_i & ~AddressMask[i]) == AddressBase[i]) begin
        a_link_o = AddressLink[i];
      end
    end
  end

  // Sink lookup for acknowledgements
  always_comb begin
    e_link_o = '0;
    for (int i = 0; i < NumSinkRange; i++) begin
      if ((e_sink_i & ~SinkMask[i]) == SinkBase[i]) begin
        e_link_o = SinkLink[i];
      end
    end
  end

endmodule

// File: source/tl_burst_tracker.sv
`timescale 1ns/10ps

module tl_burst_tracker import tl_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 d_fire_i,
  input  tl_d_op_e             d_opcode_i,
  input  logic [SizeWidth-1:0] d_size_i,
  output logic                 d_last_o
);

  logic [BeatCountWidth-1:0] beat_idx_q;
  logic [BeatCountWidth-1:0] d_len;

  // Length comes from the beat currently on the link
  assign d_len = tl_beats(d_opcode_i, d_size_i);

  assign d_last_o = (beat_idx_q == (d_len - BeatCountWidth'(1)));

  // Beat index within the current message
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_idx_q <= '0;
    end else if (d_fire_i) begin
      if (d_last_o) begin
        beat_idx_q <= '0;
      end else begin
        beat_idx_q <= beat_idx_q + BeatCountWidth'(1);
      end
    end
  end

endmodule

// File: source/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter import socket_cfg_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  logic [NumLinks-1:0] request_i,
  output logic [NumLinks-1:0] grant_o
);

  logic [LinkWidth-1:0] prio_q;
  logic [LinkWidth-1:0] winner;
  logic                 found;

  // Search starts at the priority pointer and wraps around
  always_comb begin
    int unsigned idx;
    grant_o = '0;
    winner  = '0;
    found   = 1'b0;
    for (int unsigned off = 0; off < NumLinks; off++) begin
      idx = prio_q + off;
      if (idx >= NumLinks) begin
        idx = idx - NumLinks;
      end
      if (!found && request_i[idx]) begin
        found  = 1'b1;
        winner = LinkWidth'(idx);
      end
    end
    if (enable_i && found) begin
      grant_o[winner] = 1'b1;
    end
  end

  // Winner drops to lowest priority on the next round
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q <= '0;
    end else if (enable_i && found) begin
      if (winner == LinkWidth'(NumLinks - 1)) begin
        prio_q <= '0;
      end else begin
        prio_q <= winner + LinkWidth'(1);
      end
    end
  end

endmodule

// File: source/tl_socket_1n.sv
`timescale 1ns/10ps

module tl_socket_1n import tl_pkg::*; import socket_cfg_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // Host A channel
  input  logic                                  host_a_valid_i,
  output logic                                  host_a_ready_o,
  input  tl_a_op_e                              host_a_opcode_i,
  input  logic [SizeWidth-1:0]                  host_a_size_i,
  input  logic [SourceWidth-1:0]                host_a_source_i,
  input  logic [AddrWidth-1:0]                  host_a_address_i,
  input  logic [MaskWidth-1:0]                  host_a_mask_i,
  input  logic [DataWidth-1:0]                  host_a_data_i,

  // Device A channels
  output logic [NumLinks-1:0]                   dev_a_valid_o,
  input  logic [NumLinks-1:0]                   dev_a_ready_i,
  output tl_a_op_e [NumLinks-1:0]               dev_a_opcode_o,
  output logic [NumLinks-1:0][SizeWidth-1:0]    dev_a_size_o,
  output logic [NumLinks-1:0][SourceWidth-1:0]  dev_a_source_o,
  output logic [NumLinks-1:0][AddrWidth-1:0]    dev_a_address_o,
  output logic [NumLinks-1:0][MaskWidth-1:0]    dev_a_mask_o,
  output logic [NumLinks-1:0][DataWidth-1:0]    dev_a_data_o,

  // Device D channels
  input  logic [NumLinks-1:0]                   dev_d_valid_i,
  output logic [NumLinks-1:0]                   dev_d_ready_o,
  input  tl_d_op_e [NumLinks-1:0]               dev_d_opcode_i,
  input  logic [NumLinks-1:0][SizeWidth-1:0]    dev_d_size_i,
  input  logic [NumLinks-1:0][SourceWidth-1:0]  dev_d_source_i,
  input  logic [NumLinks-1:0][SinkWidth-1:0]    dev_d_sink_i,
  input  logic [NumLinks-1:0]                   dev_d_denied_i,
  input  logic [NumLinks-1:0][DataWidth-1:0]    dev_d_data_i,

  // Host D channel
  output logic                                  host_d_valid_o,
  input  logic                                  host_d_ready_i,
  output tl_d_op_e                              host_d_opcode_o,
  output logic [SizeWidth-1:0]                  host_d_size_o,
  output logic [SourceWidth-1:0]                host_d_source_o,
  output logic [SinkWidth-1:0]                  host_d_sink_o,
  output logic                                  host_d_denied_o,
  output logic [DataWidth-1:0]                  host_d_data_o,

  // Host E channel
  input  logic                                  host_e_valid_i,
  input  logic [SinkWidth-1:0]                  host_e_sink_i,
  output logic                                  host_e_ready_o,

  // Device E channels
  output logic [NumLinks-1:0]                   dev_e_valid_o,
  output logic [NumLinks-1:0][SinkWidth-1:0]    dev_e_sink_o,
  input  logic [NumLinks-1:0]                   dev_e_ready_i
);

  logic [LinkWidth-1:0] a_link;
  logic [LinkWidth-1:0] e_link;

  tl_route_decoder u_route_decoder (
    .a_address_i (host_a_address_i),
    .e_sink_i    (host_e_sink_i),
    .a_link_o    (a_link),
    .e_link_o    (e_link)
  );

  ////////////////////////////////////////////////////////////////////////////
  // A channel demultiplexer
  ////////////////////////////////////////////////////////////////////////////

  logic [NumLinks-1:0] a_ready_sel;

  for (genvar i = 0; i < NumLinks; i++) begin : g_a_fanout
    assign dev_a_valid_o[i]   = host_a_valid_i && (a_link == LinkWidth'(i));
    assign a_ready_sel[i]     = (a_link == LinkWidth'(i)) && dev_a_ready_i[i];

    // Fields go to every link, only valid is steered
    assign dev_a_opcode_o[i]  = host_a_opcode_i;
    assign dev_a_size_o[i]    = host_a_size_i;
    assign dev_a_source_o[i]  = host_a_source_i;
    assign dev_a_address_o[i] = host_a_address_i;
    assign dev_a_mask_o[i]    = host_a_mask_i;
    assign dev_a_data_o[i]    = host_a_data_i;
  end

  assign host_a_ready_o = |a_ready_sel;

  ////////////////////////////////////////////////////////////////////////////
  // D channel arbitration
  ////////////////////////////////////////////////////////////////////////////

  logic [NumLinks-1:0] d_grant;
  logic                d_locked_q;
  logic [NumLinks-1:0] d_select_q;
  logic                d_fire;
  logic                d_last;

  rr_arbiter u_d_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .enable_i  (!d_locked_q),
    .request_i (dev_d_valid_i),
    .grant_o   (d_grant)
  );

  assign d_fire = host_d_valid_o && host_d_ready_i;

  // Beat counting on the host side decides when a burst ends
  tl_burst_tracker u_d_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .d_fire_i   (d_fire),
    .d_opcode_i (host_d_opcode_o),
    .d_size_i   (host_d_size_o),
    .d_last_o   (d_last)
  );

  // Hold the selected link until the last beat of its message
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_locked_q <= 1'b0;
      d_select_q <= '0;
    end else if (d_locked_q) begin
      if (d_fire && d_last) begin
        d_locked_q <= 1'b0;
      end
    end else if (|d_grant) begin
      d_locked_q <= 1'b1;
      d_select_q <= d_grant;
    end
  end

  for (genvar i = 0; i < NumLinks; i++) begin : g_d_ready
    assign dev_d_ready_o[i] = d_locked_q && d_select_q[i] && host_d_ready_i;
  end

  // Selected device drives the host link
  always_comb begin
    host_d_valid_o  = 1'b0;
    host_d_opcode_o = AccessAck;
    host_d_size_o   = '0;
    host_d_source_o = '0;
    host_d_sink_o   = '0;
    host_d_denied_o = 1'b0;
    host_d_data_o   = '0;
    if (d_locked_q) begin
      for (int i = 0; i < NumLinks; i++) begin
        if (d_select_q[i]) begin
          host_d_valid_o  = dev_d_valid_i[i];
          host_d_opcode_o = dev_d_opcode_i[i];
          host_d_size_o   = dev_d_size_i[i];
          host_d_source_o = dev_d_source_i[i];
          host_d_sink_o   = dev_d_sink_i[i];
          host_d_denied_o = dev_d_denied_i[i];
          host_d_data_o   = dev_d_data_i[i];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // E channel demultiplexer
  ////////////////////////////////////////////////////////////////////////////

  logic [NumLinks-1:0] e_ready_sel;

  for (genvar i = 0; i < NumLinks; i++) begin : g_e_fanout
    assign dev_e_valid_o[i] = host_e_valid_i && (e_link == LinkWidth'(i));
    assign dev_e_sink_o[i]  = host_e_sink_i;
    assign e_ready_sel[i]   = (e_link == LinkWidth'(i)) && dev_e_ready_i[i];
  end

  assign host_e_ready_o = |e_ready_sel;

endmodule

// File: verification/tl_socket_props.sv
`timescale 1ns/10ps

module tl_socket_props import socket_cfg_pkg::*; (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                host_a_valid_i,
  input logic                host_e_valid_i,
  input logic [NumLinks-1:0] dev_a_valid_o,
  input logic [NumLinks-1:0] dev_e_valid_o,
  input logic                d_locked_q,
  input logic [NumLinks-1:0] d_select_q,
  input logic                d_last,
  input logic                host_d_valid_o
);

  // Every request reaches exactly one device, idle cycles reach none
  a_valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(dev_a_valid_o) && ((dev_a_valid_o != '0) == host_a_valid_i))
    else $error("dev_a_valid_o does not select exactly one link per request");

  e_valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(dev_e_valid_o) && ((dev_e_valid_o != '0) == host_e_valid_i))
    else $error("dev_e_valid_o does not select exactly one link per acknowledgement");

  // Selection is one-hot and frozen for the whole burst
  d_select_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_locked_q |-> $onehot(d_select_q) && ($rose(d_locked_q) || $stable(d_select_q)))
    else $error("D selection not one-hot or changed while locked");

  // Unlocked means between messages, so the tracker waits for a first beat
  d_idle_unlocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !d_locked_q |-> !host_d_valid_o && d_last)
    else $error("host_d_valid_o high or burst open while unlocked");

endmodule

bind tl_socket_1n tl_socket_props u_props (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .host_a_valid_i (host_a_valid_i),
  .host_e_valid_i (host_e_valid_i),
  .dev_a_valid_o  (dev_a_valid_o),
  .dev_e_valid_o  (dev_e_valid_o),
  .d_locked_q     (d_locked_q),
  .d_select_q     (d_select_q),
  .d_last         (d_last),
  .host_d_valid_o (host_d_valid_o)
);

// File: verification/tl_socket_tb.sv
`timescale 1ns/10ps

module tl_socket_tb import tl_pkg::*; import socket_cfg_pkg::*; ();

  localparam int unsigned NumReq    = 16;
  localparam int unsigned WaitLimit = 200;
  localparam int unsigned DoneLimit = 4000;
  localparam logic [AddrWidth-1:0] RandBase [4] = '{
    32'h1000_0000, 32'h2000_0000, 32'h2800_0000, 32'h4000_0000
  };

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 host_a_valid_i;
  logic                                 host_a_ready_o;
  tl_a_op_e                             host_a_opcode_i;
  logic [SizeWidth-1:0]                 host_a_size_i;
  logic [SourceWidth-1:0]               host_a_source_i;
  logic [AddrWidth-1:0]                 host_a_address_i;
  logic [MaskWidth-1:0]                 host_a_mask_i;
  logic [DataWidth-1:0]                 host_a_data_i;
  logic [NumLinks-1:0]                  dev_a_valid_o;
  logic [NumLinks-1:0]                  dev_a_ready_i;
  tl_a_op_e [NumLinks-1:0]              dev_a_opcode_o;
  logic [NumLinks-1:0][SizeWidth-1:0]   dev_a_size_o;
  logic [NumLinks-1:0][SourceWidth-1:0] dev_a_source_o;
  logic [NumLinks-1:0][AddrWidth-1:0]   dev_a_address_o;
  logic [NumLinks-1:0][MaskWidth-1:0]   dev_a_mask_o;
  logic [NumLinks-1:0][DataWidth-1:0]   dev_a_data_o;
  logic [NumLinks-1:0]                  dev_d_valid_i;
  logic [NumLinks-1:0]                  dev_d_ready_o;
  tl_d_op_e [NumLinks-1:0]              dev_d_opcode_i;
  logic [NumLinks-1:0][SizeWidth-1:0]   dev_d_size_i;
  logic [NumLinks-1:0][SourceWidth-1:0] dev_d_source_i;
  logic [NumLinks-1:0][SinkWidth-1:0]   dev_d_sink_i;
  logic [NumLinks-1:0]                  dev_d_denied_i;
  logic [NumLinks-1:0][DataWidth-1:0]   dev_d_data_i;
  logic                                 host_d_valid_o;
  logic                                 host_d_ready_i;
  tl_d_op_e                             host_d_opcode_o;
  logic [SizeWidth-1:0]                 host_d_size_o;
  logic [SourceWidth-1:0]               host_d_source_o;
  logic [SinkWidth-1:0]                 host_d_sink_o;
  logic                                 host_d_denied_o;
  logic [DataWidth-1:0]                 host_d_data_o;
  logic                                 host_e_valid_i;
  logic [SinkWidth-1:0]                 host_e_sink_i;
  logic                                 host_e_ready_o;
  logic [NumLinks-1:0]                  dev_e_valid_o;
  logic [NumLinks-1:0][SinkWidth-1:0]   dev_e_sink_o;
  logic [NumLinks-1:0]                  dev_e_ready_i;

  int unsigned errors;
  int unsigned timeouts;
  int unsigned msgs_done;
  bit          d_release;

  // Expected response per source, recorded when the request is sent
  tl_d_op_e             exp_op [1 << SourceWidth];
  logic [SizeWidth-1:0] exp_size [1 << SourceWidth];
  logic [LinkWidth-1:0] exp_link [1 << SourceWidth];
  int                   outstanding [1 << SourceWidth];

  // Device models, request word is {opcode, size, source}
  logic [9:0]  pend_q [NumLinks][$];
  bit          dev_busy [NumLinks];
  int unsigned dev_beat [NumLinks];

  // Host side D tracking
  int unsigned          host_beat;
  logic [SourceWidth-1:0] host_src;
  logic [LinkWidth-1:0] msg_link;
  bit [NumLinks-1:0]    wait_snap;
  bit [NumLinks-1:0]    served_mask [NumLinks];

  tl_socket_1n dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Highest matching range wins, unmapped space goes to link 0
  function automatic logic [LinkWidth-1:0] ref_link_of_addr(input logic [AddrWidth-1:0] addr);
    if (addr[31:24] == 8'h28) return 2'd1;
    if (addr[31:28] == 4'h2) return 2'd2;
    if (addr[31:28] == 4'h1) return 2'd1;
    return 2'd0;
  endfunction

  function automatic logic [LinkWidth-1:0] ref_link_of_sink(input logic [SinkWidth-1:0] sink);
    return (sink == 2'd1 || sink == 2'd2) ? LinkWidth'(sink) : 2'd0;
  endfunction

  // Data messages carry one beat per 4 bytes, all others a single beat
  function automatic int unsigned ref_beats(input tl_d_op_e op, input logic [SizeWidth-1:0] size);
    int unsigned bytes;
    if (!(op == AccessAckData || op == GrantData)) return 1;
    bytes = 1 << ((size > 3'd4) ? 4 : size);
    return (bytes <= 4) ? 1 : bytes / 4;
  endfunction

  function automatic tl_d_op_e ref_d_op(input tl_a_op_e op);
    case (op)
      Get:          return AccessAckData;
      AcquireBlock: return GrantData;
      default:      return AccessAck;
    endcase
  endfunction

  function automatic logic [DataWidth-1:0] data_word(input logic [SourceWidth-1:0] src,
                                                     input int unsigned beat);
    return {8'hD5, 4'h0, src, 8'h00, 8'(beat)};
  endfunction

  // Index of the single set bit, all ones when none or several are set
  function automatic logic [LinkWidth-1:0] onehot_link(input logic [NumLinks-1:0] vec);
    if ($countones(vec) != 1) return '1;
    for (int i = 0; i < NumLinks; i++) begin
      if (vec[i]) return LinkWidth'(i);
    end
    return '1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_link(input string name, input logic [LinkWidth-1:0] got,
                            input logic [LinkWidth-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_a_opcode(input string name, input tl_a_op_e got, input tl_a_op_e exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_d_opcode(input string name, input tl_d_op_e got, input tl_d_op_e exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_size(input string name, input logic [SizeWidth-1:0] got,
                            input logic [SizeWidth-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_mask(input string name, input logic [MaskWidth-1:0] got,
                            input logic [MaskWidth-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_data(input string name, input logic [DataWidth-1:0] got,
                            input logic [DataWidth-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_source(input string name, input logic [SourceWidth-1:0] got,
                              input logic [SourceWidth-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_sink(input string name, input logic [SinkWidth-1:0] got,
                            input logic [SinkWidth-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // No link may be served twice while another one waits
  task automatic note_round(input logic [LinkWidth-1:0] link);
    for (int k = 0; k < NumLinks; k++) begin
      if (k == link || !wait_snap[k]) begin
        served_mask[k] = '0;
      end else if (served_mask[k][link]) begin
        errors++;
        $display("Link %0d was served twice while link %0d waited", link, k);
      end else begin
        served_mask[k][link] = 1'b1;
      end
    end
    wait_snap = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Device models and back-pressure
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    logic [9:0] req;
    dev_a_ready_i  = NumLinks'($urandom);
    dev_e_ready_i  = NumLinks'($urandom);
    host_d_ready_i = ($urandom % 4) != 0;
    for (int i = 0; i < NumLinks; i++) begin
      req = '0;
      if (!dev_busy[i] && d_release && pend_q[i].size() > 0) begin
        dev_busy[i] = 1'b1;
        dev_beat[i] = 0;
      end
      if (dev_busy[i]) begin
        req = pend_q[i][0];
      end
      dev_d_valid_i[i]  = dev_busy[i];
      dev_d_opcode_i[i] = ref_d_op(tl_a_op_e'(req[9:7]));
      dev_d_size_i[i]   = req[6:4];
      dev_d_source_i[i] = req[3:0];
      dev_d_sink_i[i]   = SinkWidth'(i);
      // Odd sources are answered as denied
      dev_d_denied_i[i] = req[0];
      dev_d_data_i[i]   = data_word(req[3:0], dev_beat[i]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [NumLinks-1:0]  d_fire_vec;
    logic [LinkWidth-1:0] link;
    if (rst_ni) begin
      if (host_a_valid_i) begin
        link = ref_link_of_addr(host_a_address_i);
        check_link("dev_a_valid_o", onehot_link(dev_a_valid_o), link);
        check_bit("host_a_ready_o", host_a_ready_o, dev_a_ready_i[link]);
        if (host_a_ready_o) begin
          check_a_opcode("dev_a_opcode_o", dev_a_opcode_o[link], host_a_opcode_i);
          check_size("dev_a_size_o", dev_a_size_o[link], host_a_size_i);
          check_data("dev_a_address_o", dev_a_address_o[link], host_a_address_i);
          check_mask("dev_a_mask_o", dev_a_mask_o[link], host_a_mask_i);
          check_data("dev_a_data_o", dev_a_data_o[link], host_a_data_i);
          check_source("dev_a_source_o", dev_a_source_o[link], host_a_source_i);
        end
      end
      for (int i = 0; i < NumLinks; i++) begin
        if (dev_a_valid_o[i] && dev_a_ready_i[i]) begin
          pend_q[i].push_back({dev_a_opcode_o[i], dev_a_size_o[i], dev_a_source_o[i]});
        end
      end
      if (host_e_valid_i) begin
        link = ref_link_of_sink(host_e_sink_i);
        check_link("dev_e_valid_o", onehot_link(dev_e_valid_o), link);
        check_bit("host_e_ready_o", host_e_ready_o, dev_e_ready_i[link]);
        check_sink("dev_e_sink_o", dev_e_sink_o[link], host_e_sink_i);
      end
      d_fire_vec = dev_d_valid_i & dev_d_ready_o;
      if (host_d_valid_o && host_d_ready_i) begin
        link = onehot_link(d_fire_vec);
        if (host_beat == 0) begin
          if (outstanding[host_d_source_o] <= 0) begin
            errors++;
            $display("Response for source %0d arrived without an open request", host_d_source_o);
          end
          host_src = host_d_source_o;
          msg_link = link;
          check_link("dev_d_ready_o", link, exp_link[host_src]);
          note_round(link);
        end else begin
          check_link("dev_d_ready_o", link, msg_link);
          check_source("host_d_source_o", host_d_source_o, host_src);
        end
        check_d_opcode("host_d_opcode_o", host_d_opcode_o, exp_op[host_src]);
        check_size("host_d_size_o", host_d_size_o, exp_size[host_src]);
        check_sink("host_d_sink_o", host_d_sink_o, SinkWidth'(exp_link[host_src]));
        check_bit("host_d_denied_o", host_d_denied_o, host_src[0]);
        check_data("host_d_data_o", host_d_data_o, data_word(host_src, host_beat));
        if (host_beat + 1 == ref_beats(exp_op[host_src], exp_size[host_src])) begin
          outstanding[host_src]--;
          msgs_done++;
          host_beat = 0;
          // Links still waiting when the lock releases
          wait_snap = dev_d_valid_i;
          wait_snap[msg_link] = 1'b0;
        end else begin
          host_beat++;
        end
      end else if (d_fire_vec != '0) begin
        errors++;
        $display("A device D beat was taken without a host transfer at %0t", $time);
      end
      for (int i = 0; i < NumLinks; i++) begin
        if (d_fire_vec[i]) begin
          if (dev_beat[i] + 1 == tl_beats(dev_d_opcode_i[i], dev_d_size_i[i])) begin
            void'(pend_q[i].pop_front());
            dev_busy[i] = 1'b0;
            dev_beat[i] = 0;
          end else begin
            dev_beat[i]++;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic init_inputs();
    rst_ni           = 1'b0;
    host_a_valid_i   = 1'b0;
    host_a_opcode_i  = PutFullData;
    host_a_size_i    = '0;
    host_a_source_i  = '0;
    host_a_address_i = '0;
    host_a_mask_i    = '0;
    host_a_data_i    = '0;
    host_d_ready_i   = 1'b0;
    host_e_valid_i   = 1'b0;
    host_e_sink_i    = '0;
    dev_a_ready_i    = '0;
    dev_e_ready_i    = '0;
    dev_d_valid_i    = '0;
    dev_d_size_i     = '0;
    dev_d_source_i   = '0;
    dev_d_sink_i     = '0;
    dev_d_denied_i   = '0;
    dev_d_data_i     = '0;
    for (int i = 0; i < NumLinks; i++) begin
      dev_d_opcode_i[i] = AccessAck;
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("Timeout: %s at %0t", what, $time);
  endtask

  task automatic send_a(input tl_a_op_e op, input logic [SizeWidth-1:0] size,
                        input logic [SourceWidth-1:0] src, input logic [AddrWidth-1:0] addr);
    int unsigned cycles;
    if (timeouts != 0) return;
    @(negedge clk_i);
    host_a_valid_i   = 1'b1;
    host_a_opcode_i  = op;
    host_a_size_i    = size;
    host_a_source_i  = src;
    host_a_address_i = addr;
    host_a_mask_i    = MaskWidth'($urandom);
    host_a_data_i    = $urandom;
    exp_op[src]      = ref_d_op(op);
    exp_size[src]    = size;
    exp_link[src]    = ref_link_of_addr(addr);
    outstanding[src]++;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!host_a_ready_o && cycles < WaitLimit);
    if (!host_a_ready_o) note_timeout("A request was never accepted");
    @(negedge clk_i);
    host_a_valid_i = 1'b0;
  endtask

  task automatic send_e(input logic [SinkWidth-1:0] sink);
    int unsigned cycles;
    if (timeouts != 0) return;
    @(negedge clk_i);
    host_e_valid_i = 1'b1;
    host_e_sink_i  = sink;
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
    end while (!host_e_ready_o && cycles < WaitLimit);
    if (!host_e_ready_o) note_timeout("E acknowledgement was never accepted");
    @(negedge clk_i);
    host_e_valid_i = 1'b0;
  endtask

  initial begin
    logic [AddrWidth-1:0] addr;
    int unsigned          pick;
    int unsigned          cycles;
    void'($urandom(32'h67306613));
    init_inputs();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Each range, the overlap and unmapped space
    send_a(Get,          3'd4, 4'd0, 32'h1000_0040);
    send_a(AcquireBlock, 3'd4, 4'd1, 32'h2000_0100);
    send_a(Get,          3'd3, 4'd2, 32'h2800_0200);
    send_a(PutFullData,  3'd2, 4'd3, 32'h2900_0000);
    send_a(Get,          3'd4, 4'd4, 32'h0000_1000);
    send_a(AcquireBlock, 3'd3, 4'd5, 32'h3000_0000);
    for (int n = 6; n < NumReq; n++) begin
      addr = RandBase[$urandom % 4] | ($urandom & 32'h00FF_FFFC);
      pick = $urandom % 3;
      send_a((pick == 0) ? PutFullData : ((pick == 1) ? Get : AcquireBlock),
             SizeWidth'($urandom % 5), SourceWidth'(n), addr);
    end
    for (int s = 0; s < 4; s++) begin
      send_e(SinkWidth'(s));
    end
    // All devices answer from here on, so they contend at once
    @(posedge clk_i);
    d_release = 1'b1;
    cycles = 0;
    while (msgs_done < NumReq && cycles < DoneLimit && timeouts == 0) begin
      @(posedge clk_i);
      cycles++;
    end
    if (msgs_done < NumReq) note_timeout("not every D message reached the host");
    for (int s = 0; s < NumReq; s++) begin
      if (outstanding[s] != 0) begin
        errors++;
        $display("Source %0d left %0d responses open", s, outstanding[s]);
      end
    end
    $display("Errors: %0d, timeouts: %0d, messages: %0d", errors, timeouts, msgs_done);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb.f
source/tl_pkg.sv
source/socket_cfg_pkg.sv
source/tl_route_decoder.sv
source/tl_burst_tracker.sv
source/rr_arbiter.sv
source/tl_socket_1n.sv
verification/tl_socket_props.sv
verification/tl_socket_tb.sv

// File: Bender.yml
package:
  name: tl_socket_1n

sources:
  # Packages first, then the modules that use them
  - files:
      - source/tl_pkg.sv
      - source/socket_cfg_pkg.sv
      - source/tl_route_decoder.sv
      - source/tl_burst_tracker.sv
      - source/rr_arbiter.sv
      - source/tl_socket_1n.sv

  - target: test
    files:
      - verification/tl_socket_props.sv
      - verification/tl_socket_tb.sv
